/* histCfg_cfg.svh */
`ifndef HIST_CFG_SVH
`define HIST_CFG_SVH

// timestamp code and bin geometry
`define HF_CODE_BITS 8
`define HF_BIN_BITS 4
`define HF_BINS 16
`define HF_HALF_BIN 8

// pixel array and sample order
`define HF_PIXELS 4
`define HF_SAMPLES_PER_PIXEL 4
`define HF_ACQ_NUM 2

// bin counters
`define HF_COUNT_BITS 8

// wishbone port
`define HF_WB_ADR_BITS 4
`define HF_WB_DAT_BITS 32

// register map, pixel p at HF_ADR_RESULT0 + p
`define HF_ADR_SAMPLE 0
`define HF_ADR_RESULT0 1

`endif

/* histPkg.sv */
`default_nettype none

`include "histCfg_cfg.svh"

package histPkg;

    // which histogram pass is running
    typedef enum logic {
        PASS_COARSE = 1'b0,
        PASS_FINE   = 1'b1
    } passT;

    // host side request
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`HF_WB_ADR_BITS-1:0] adr;
        logic [`HF_WB_DAT_BITS-1:0] dat;
    } wbReqT;

    typedef struct packed {
        logic                       ack;
        logic [`HF_WB_DAT_BITS-1:0] dat;
    } wbRspT;

    // one increment request into the histogram memory
    typedef struct packed {
        logic                           valid;
        logic [$clog2(`HF_PIXELS)-1:0]  pixel;
        logic [`HF_BIN_BITS-1:0]        bin;
    } binUpdT;

    // counter value right after its increment
    typedef struct packed {
        logic                           valid;
        logic [$clog2(`HF_PIXELS)-1:0]  pixel;
        logic [`HF_BIN_BITS-1:0]        bin;
        logic [`HF_COUNT_BITS-1:0]      count;
    } binCountT;

    typedef struct packed {
        logic [$clog2(`HF_PIXELS)-1:0]  pixel;
        logic [`HF_BIN_BITS-1:0]        bin;
    } peakT;

    // field order gives the read layout 19:16, 15:8, 7:0
    typedef struct packed {
        logic [`HF_BIN_BITS-1:0]  coarseBin;
        logic [`HF_CODE_BITS-1:0] windowLow;
        logic [`HF_CODE_BITS-1:0] fineCode;
    } pixelResultT;

endpackage

`default_nettype wire

/* wbSampleSlave.sv */
`default_nettype none

`include "histCfg_cfg.svh"

module wbSampleSlave import histPkg::*; (
    input  wire                        clk,
    input  wire                        combin_res,
    input  wire wbReqT                 wbReq,
    output wbRspT                      wbRsp,
    input  wire                        clearBusy,
    output logic                       sampleValid,
    output logic [`HF_CODE_BITS-1:0]   sampleCode,
    output logic [`HF_WB_ADR_BITS-1:0] rdAdr,
    input  wire [`HF_WB_DAT_BITS-1:0]  rdData
);

    logic                       ackQ;
    logic [`HF_WB_DAT_BITS-1:0] datQ;
    logic                       reqLive;
    logic                       sampleHit;

    // request seen and not yet acked, held off while memory clears
    assign reqLive   = wbReq.cyc && wbReq.stb && !ackQ && !clearBusy;
    assign sampleHit = reqLive && wbReq.we && (wbReq.adr == `HF_ADR_SAMPLE);

    // read mux lives in resultFile, address goes straight through
    assign rdAdr = wbReq.adr;

    assign wbRsp.ack = ackQ;
    assign wbRsp.dat = datQ;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            ackQ        <= 1'b0;
            sampleValid <= 1'b0;
        end else begin
            // single cycle ack, one clock after the request
            ackQ        <= reqLive;
            sampleValid <= sampleHit;
        end
    end

    // data registers
    always_ff @(posedge clk) begin
        if (reqLive) begin
            // writes return zero, reads return the register
            datQ <= wbReq.we ? '0 : rdData;
        end
        if (sampleHit) begin
            sampleCode <= wbReq.dat[`HF_CODE_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

/* binSequencer.sv */
`default_nettype none

`include "histCfg_cfg.svh"

module binSequencer import histPkg::*; (
    input  wire                                      clk,
    input  wire                                      combin_res,
    input  wire                                      sampleValid,
    input  wire [`HF_CODE_BITS-1:0]                  sampleCode,
    input  wire [`HF_PIXELS-1:0][`HF_CODE_BITS-1:0]  windowLow,
    output binUpdT                                   binUpd,
    output logic                                     passEnd,
    output logic                                     clearBusy,
    output logic [$clog2(`HF_PIXELS*`HF_BINS)-1:0]   clearAdr,
    output passT                                     passState
);

    localparam int SAMPLE_BITS = $clog2(`HF_SAMPLES_PER_PIXEL);
    localparam int PIXEL_BITS  = $clog2(`HF_PIXELS);
    localparam int ACQ_BITS    = $clog2(`HF_ACQ_NUM);

    logic [SAMPLE_BITS-1:0]    sampleCnt;
    logic [PIXEL_BITS-1:0]     pixelCnt;
    logic [ACQ_BITS-1:0]       acqCnt;
    logic                      lastInPixel;
    logic                      lastPixel;
    logic                      lastSample;
    logic [`HF_CODE_BITS:0]    fineDiff;
    logic [`HF_BIN_BITS-1:0]   mappedBin;
    logic                      inWindow;
    logic [2:0]                endPipe;
    logic                      initSweep;
    logic                      flipPending;

    assign lastInPixel = (sampleCnt == SAMPLE_BITS'(`HF_SAMPLES_PER_PIXEL - 1));
    assign lastPixel   = (pixelCnt == PIXEL_BITS'(`HF_PIXELS - 1));
    assign lastSample  = lastInPixel && lastPixel && (acqCnt == ACQ_BITS'(`HF_ACQ_NUM - 1));

    // extra msb catches codes below the window
    assign fineDiff = {1'b0, sampleCode} - {1'b0, windowLow[pixelCnt]};

    always_comb begin
        if (passState == PASS_COARSE) begin
            // coarse bin is just the top bits
            mappedBin = sampleCode[`HF_CODE_BITS-1 -: `HF_BIN_BITS];
            inWindow  = 1'b1;
        end else begin
            mappedBin = fineDiff[`HF_BIN_BITS-1:0];
            inWindow  = (fineDiff[`HF_CODE_BITS:`HF_BIN_BITS] == '0);
        end
    end

    // sample order counters and bin request
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
            binUpd    <= '0;
        end else begin
            // dropped samples still step the counters
            binUpd.valid <= sampleValid && inWindow;
            binUpd.pixel <= pixelCnt;
            binUpd.bin   <= mappedBin;
            if (sampleValid) begin
                if (lastInPixel) begin
                    sampleCnt <= '0;
                    if (lastPixel) begin
                        pixelCnt <= '0;
                        if (acqCnt == ACQ_BITS'(`HF_ACQ_NUM - 1)) begin
                            acqCnt <= '0;
                        end else begin
                            acqCnt <= acqCnt + 1'b1;
                        end
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

    // pass end timing, clear sweep and pass flip
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            endPipe     <= '0;
            passEnd     <= 1'b0;
            clearBusy   <= 1'b0;
            clearAdr    <= '0;
            initSweep   <= 1'b1;
            flipPending <= 1'b0;
            passState   <= PASS_COARSE;
        end else begin
            // last sample walks down the pipe, passEnd lands after the peak update
            endPipe <= {endPipe[1:0], sampleValid && lastSample};
            passEnd <= endPipe[2];
            if (endPipe[0] || initSweep) begin
                clearBusy   <= 1'b1;
                clearAdr    <= '0;
                initSweep   <= 1'b0;
                // the sweep after reset keeps the coarse pass
                flipPending <= endPipe[0];
            end else if (clearBusy) begin
                clearAdr <= clearAdr + 1'b1;
                if (clearAdr == '1) begin
                    clearBusy <= 1'b0;
                    if (flipPending) begin
                        passState <= (passState == PASS_COARSE) ? PASS_FINE : PASS_COARSE;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* histogramBank.sv */
`default_nettype none

`include "histCfg_cfg.svh"

module histogramBank import histPkg::*; (
    input  wire                                    clk,
    input  wire                                    combin_res,
    input  wire binUpdT                            binUpd,
    input  wire                                    clearBusy,
    input  wire [$clog2(`HF_PIXELS*`HF_BINS)-1:0]  clearAdr,
    output binCountT                               binCount
);

    localparam int DEPTH    = `HF_PIXELS * `HF_BINS;
    localparam int ADR_BITS = $clog2(DEPTH);

    // one 16 bin histogram per pixel, pixel in the upper address bits
    logic [`HF_COUNT_BITS-1:0] mem [DEPTH];
    logic [ADR_BITS-1:0]       updAdr;
    logic [`HF_COUNT_BITS-1:0] newCount;
    logic                      doInc;

    assign updAdr   = {binUpd.pixel, binUpd.bin};
    assign newCount = mem[updAdr] + 1'b1;
    // sweep owns the memory while it runs
    assign doInc    = binUpd.valid && !clearBusy;

    always_ff @(posedge clk) begin
        if (clearBusy) begin
            mem[clearAdr] <= '0;
        end else if (doInc) begin
            mem[updAdr] <= newCount;
        end
    end

    // new count for the peak tracker
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binCount <= '0;
        end else begin
            binCount.valid <= doInc;
            binCount.pixel <= binUpd.pixel;
            binCount.bin   <= binUpd.bin;
            binCount.count <= newCount;
        end
    end

endmodule

`default_nettype wire

/* peakTracker.sv */
`default_nettype none

`include "histCfg_cfg.svh"

module peakTracker import histPkg::*; (
    input  wire            clk,
    input  wire            combin_res,
    input  wire binCountT  binCount,
    input  wire            passEnd,
    output peakT           peak,
    output logic           peakValid
);

    localparam int PIXEL_BITS = $clog2(`HF_PIXELS);

    logic [`HF_COUNT_BITS-1:0] maxCount [`HF_PIXELS];
    logic [`HF_BIN_BITS-1:0]   peakBin [`HF_PIXELS];
    logic                      emitting;
    logic [PIXEL_BITS-1:0]     emitIdx;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `HF_PIXELS; p++) begin
                maxCount[p] <= '0;
                peakBin[p]  <= '0;
            end
            emitting  <= 1'b0;
            emitIdx   <= '0;
            peak      <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= emitting;
            if (emitting) begin
                // one pixel per cycle
                peak.pixel <= emitIdx;
                peak.bin   <= peakBin[emitIdx];
                emitIdx    <= emitIdx + 1'b1;
                if (emitIdx == PIXEL_BITS'(`HF_PIXELS - 1)) begin
                    emitting <= 1'b0;
                    // fresh start for the next pass
                    for (int p = 0; p < `HF_PIXELS; p++) begin
                        maxCount[p] <= '0;
                        peakBin[p]  <= '0;
                    end
                end
            end else if (passEnd) begin
                emitting <= 1'b1;
                emitIdx  <= '0;
            end else if (binCount.valid && (binCount.count > maxCount[binCount.pixel])) begin
                // strictly greater, so a tie keeps the earlier bin
                maxCount[binCount.pixel] <= binCount.count;
                peakBin[binCount.pixel]  <= binCount.bin;
            end
        end
    end

endmodule

`default_nettype wire

/* resultFile.sv */
`default_nettype none

`include "histCfg_cfg.svh"

module resultFile import histPkg::*; (
    input  wire                                      clk,
    input  wire                                      combin_res,
    input  wire peakT                                peak,
    input  wire                                      peakValid,
    input  wire passT                                passState,
    output logic [`HF_PIXELS-1:0][`HF_CODE_BITS-1:0] windowLow,
    input  wire [`HF_WB_ADR_BITS-1:0]                rdAdr,
    output logic [`HF_WB_DAT_BITS-1:0]               rdData
);

    localparam int PIXEL_BITS = $clog2(`HF_PIXELS);
    // highest low edge that still fits a full window
    localparam int WIN_MAX    = (1 << `HF_CODE_BITS) - `HF_BINS;

    pixelResultT                results [`HF_PIXELS];
    logic [`HF_COUNT_BITS-1:0]  measCount;
    logic [`HF_CODE_BITS-1:0]   binBase;
    logic [`HF_CODE_BITS-1:0]   lowRaw;
    logic [`HF_CODE_BITS-1:0]   clampedLow;
    logic [PIXEL_BITS-1:0]      rdPixel;

    // coarse bin times bin width
    assign binBase = {peak.bin, {(`HF_CODE_BITS - `HF_BIN_BITS){1'b0}}};
    assign lowRaw  = binBase - `HF_CODE_BITS'(`HF_HALF_BIN);

    always_comb begin
        if (binBase < `HF_CODE_BITS'(`HF_HALF_BIN)) begin
            clampedLow = '0;
        end else if (lowRaw > `HF_CODE_BITS'(WIN_MAX)) begin
            clampedLow = `HF_CODE_BITS'(WIN_MAX);
        end else begin
            clampedLow = lowRaw;
        end
    end

    always_comb begin
        for (int p = 0; p < `HF_PIXELS; p++) begin
            windowLow[p] = results[p].windowLow;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `HF_PIXELS; p++) begin
                results[p] <= '0;
            end
            measCount <= '0;
        end else if (peakValid) begin
            if (passState == PASS_COARSE) begin
                results[peak.pixel].coarseBin <= peak.bin;
                results[peak.pixel].windowLow <= clampedLow;
            end else begin
                results[peak.pixel].fineCode <=
                    results[peak.pixel].windowLow + `HF_CODE_BITS'(peak.bin);
                // measurement done with the last pixel
                if (peak.pixel == PIXEL_BITS'(`HF_PIXELS - 1)) begin
                    measCount <= measCount + 1'b1;
                end
            end
        end
    end

    // register read mux
    assign rdPixel = PIXEL_BITS'(rdAdr - `HF_WB_ADR_BITS'(`HF_ADR_RESULT0));

    always_comb begin
        rdData = '0;
        if (rdAdr == `HF_WB_ADR_BITS'(`HF_ADR_SAMPLE)) begin
            // status word
            rdData[`HF_COUNT_BITS-1:0] = measCount;
            rdData[`HF_COUNT_BITS]     = (passState == PASS_FINE);
        end else if ((rdAdr >= `HF_WB_ADR_BITS'(`HF_ADR_RESULT0)) &&
                     (rdAdr < `HF_WB_ADR_BITS'(`HF_ADR_RESULT0 + `HF_PIXELS))) begin
            rdData[$bits(pixelResultT)-1:0] = results[rdPixel];
        end
    end

endmodule

`default_nettype wire

/* peakFinderTop.sv */
`default_nettype none

`include "histCfg_cfg.svh"

module peakFinderTop import histPkg::*; (
    input  wire         clk,
    input  wire         combin_res,
    input  wire wbReqT  wbReq,
    output wbRspT       wbRsp,
    output passT        passState
);

    // bus side
    logic                                     sampleValid;
    logic [`HF_CODE_BITS-1:0]                 sampleCode;
    logic [`HF_WB_ADR_BITS-1:0]               rdAdr;
    logic [`HF_WB_DAT_BITS-1:0]               rdData;

    // processing part
    logic                                     clearBusy;
    logic [$clog2(`HF_PIXELS*`HF_BINS)-1:0]   clearAdr;
    logic [`HF_PIXELS-1:0][`HF_CODE_BITS-1:0] windowLow;
    binUpdT                                   binUpd;
    binCountT                                 binCount;
    logic                                     passEnd;

    // result side
    peakT                                     peak;
    logic                                     peakValid;

    wbSampleSlave i_slave (
        .clk         (clk),
        .combin_res  (combin_res),
        .wbReq       (wbReq),
        .wbRsp       (wbRsp),
        .clearBusy   (clearBusy),
        .sampleValid (sampleValid),
        .sampleCode  (sampleCode),
        .rdAdr       (rdAdr),
        .rdData      (rdData)
    );

    binSequencer i_seq (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .sampleCode  (sampleCode),
        .windowLow   (windowLow),
        .binUpd      (binUpd),
        .passEnd     (passEnd),
        .clearBusy   (clearBusy),
        .clearAdr    (clearAdr),
        .passState   (passState)
    );

    histogramBank i_bank (
        .clk        (clk),
        .combin_res (combin_res),
        .binUpd     (binUpd),
        .clearBusy  (clearBusy),
        .clearAdr   (clearAdr),
        .binCount   (binCount)
    );

    peakTracker i_peak (
        .clk        (clk),
        .combin_res (combin_res),
        .binCount   (binCount),
        .passEnd    (passEnd),
        .peak       (peak),
        .peakValid  (peakValid)
    );

    resultFile i_result (
        .clk        (clk),
        .combin_res (combin_res),
        .peak       (peak),
        .peakValid  (peakValid),
        .passState  (passState),
        .windowLow  (windowLow),
        .rdAdr      (rdAdr),
        .rdData     (rdData)
    );

endmodule

`default_nettype wire

/* peakFinderTb.sv */
`default_nettype none

`include "histCfg_cfg.svh"

module peakFinderTb import histPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF     = 4;
    localparam int NUM_MEAS     = 5;
    localparam int ACK_LIMIT    = 100;
    localparam int CODE_PER_BIN = 1 << (`HF_CODE_BITS - `HF_BIN_BITS);
    localparam int CODE_MAX     = (1 << `HF_CODE_BITS) - 1;
    localparam int LOW_MAX      = (1 << `HF_CODE_BITS) - `HF_BINS;
    // writes plus clear sweeps plus reset in clock cycles
    localparam int WATCHDOG_CYCLES = NUM_MEAS * 128 * 8 + 10 * 70 + 3 + 64;

    logic        clk;
    logic        combin_res;
    wbReqT       wbReq;
    wbRspT       wbRsp;
    passT        passState;

    logic [31:0] rngState;
    int          writesIssued;
    int          acksSeen;
    int          noHitPixel;

    // reference model state
    int hist [`HF_PIXELS][`HF_BINS];
    int bestCount [`HF_PIXELS];
    int bestBin [`HF_PIXELS];
    int centers [`HF_PIXELS];
    int expCoarse [`HF_PIXELS];
    int expLow [`HF_PIXELS];
    int expFine [`HF_PIXELS];

    peakFinderTop i_dut (
        .clk        (clk),
        .combin_res (combin_res),
        .wbReq      (wbReq),
        .wbRsp      (wbRsp),
        .passState  (passState)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // hard stop in case the DUT locks up
    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        failRun("watchdog expired before all measurements finished");
    end

    // every ack cycle on a write counts once
    always @(negedge clk) begin
        if (wbRsp.ack && wbReq.we) begin
            acksSeen++;
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else failRun($sformatf(
            "mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // window low edge from a coarse bin clamped to the code range
    function automatic int clampLow(input int coarseBin);
        int v;
        v = coarseBin * CODE_PER_BIN - `HF_HALF_BIN;
        if (v < 0) begin
            v = 0;
        end
        if (v > LOW_MAX) begin
            v = LOW_MAX;
        end
        return v;
    endfunction

    function automatic int makeCode(input int pixel, input bit fine);
        logic [31:0] r;
        int          v;
        r = nextRand();
        if (fine && (pixel == noHitPixel)) begin
            // far away from the whole window
            v = (expLow[pixel] >= 128) ? int'(r[5:0]) : 192 + int'(r[5:0]);
        end else if (r[1:0] == 2'b00) begin
            // stray code anywhere
            v = int'(r[15:8]);
        end else begin
            v = centers[pixel] + int'(r[11:8]) - 7;
            if (v < 0) begin
                v = 0;
            end
            if (v > CODE_MAX) begin
                v = CODE_MAX;
            end
        end
        return v;
    endfunction

    // one classic cycle held until ack
    task automatic busAccess(input logic we, input logic [`HF_WB_ADR_BITS-1:0] adr,
                             input logic [`HF_WB_DAT_BITS-1:0] wdat,
                             output logic [`HF_WB_DAT_BITS-1:0] rdat);
        wbReqT req;
        int    waitCycles;
        req.cyc    = 1'b1;
        req.stb    = 1'b1;
        req.we     = we;
        req.adr    = adr;
        req.dat    = wdat;
        waitCycles = 0;
        @(posedge clk);
        wbReq <= req;
        if (we) begin
            writesIssued++;
        end
        // ack sampled mid cycle
        @(negedge clk);
        while (!wbRsp.ack) begin
            waitCycles++;
            assert (waitCycles < ACK_LIMIT) else failRun("slave never acknowledged a request");
            @(negedge clk);
        end
        rdat = wbRsp.dat;
        @(posedge clk);
        // strobe low for a cycle after ack
        wbReq <= '0;
    endtask

    // one full pass of samples with the model updated alongside
    task automatic runPass(input bit fine);
        int          code;
        int          bin;
        int          diff;
        logic [31:0] rd;
        for (int p = 0; p < `HF_PIXELS; p++) begin
            bestCount[p] = 0;
            bestBin[p]   = 0;
            for (int b = 0; b < `HF_BINS; b++) begin
                hist[p][b] = 0;
            end
        end
        for (int a = 0; a < `HF_ACQ_NUM; a++) begin
            for (int p = 0; p < `HF_PIXELS; p++) begin
                for (int s = 0; s < `HF_SAMPLES_PER_PIXEL; s++) begin
                    code = makeCode(p, fine);
                    busAccess(1'b1, `HF_WB_ADR_BITS'(`HF_ADR_SAMPLE), 32'(code), rd);
                    diff = code - expLow[p];
                    bin  = fine ? diff : code / CODE_PER_BIN;
                    // out of window codes are dropped
                    if (!fine || ((diff >= 0) && (diff < `HF_BINS))) begin
                        hist[p][bin]++;
                        // first bin to reach the top count wins
                        if (hist[p][bin] > bestCount[p]) begin
                            bestCount[p] = hist[p][bin];
                            bestBin[p]   = bin;
                        end
                    end
                end
            end
        end
        for (int p = 0; p < `HF_PIXELS; p++) begin
            if (fine) begin
                expFine[p] = expLow[p] + bestBin[p];
            end else begin
                expCoarse[p] = bestBin[p];
                expLow[p]    = clampLow(bestBin[p]);
            end
        end
        checkValue("write acks", 32'(acksSeen), 32'(writesIssued));
    endtask

    // status word and all result registers
    task automatic checkRegs(input int measDone, input bit finePass);
        logic [31:0] rd;
        logic [31:0] exp;
        busAccess(1'b0, `HF_WB_ADR_BITS'(`HF_ADR_SAMPLE), 32'd0, rd);
        exp = {23'd0, finePass, 8'(measDone)};
        checkValue("status", rd, exp);
        checkValue("passState", 32'(passState), 32'(finePass));
        for (int p = 0; p < `HF_PIXELS; p++) begin
            busAccess(1'b0, `HF_WB_ADR_BITS'(`HF_ADR_RESULT0 + p), 32'd0, rd);
            exp = {12'd0, 4'(expCoarse[p]), 8'(expLow[p]), 8'(expFine[p])};
            checkValue($sformatf("result%0d", p), rd, exp);
        end
    endtask

    initial begin
        rngState     = 32'h543f6c35;
        combin_res   = 1'b0;
        wbReq        = '0;
        writesIssued = 0;
        acksSeen     = 0;
        noHitPixel   = -1;
        for (int p = 0; p < `HF_PIXELS; p++) begin
            centers[p]   = 0;
            expCoarse[p] = 0;
            expLow[p]    = 0;
            expFine[p]   = 0;
        end
        repeat (3) @(posedge clk);
        combin_res <= 1'b1;

        // reads stall until the reset sweep is done
        checkRegs(0, 1'b0);

        for (int m = 0; m < NUM_MEAS; m++) begin
            for (int p = 0; p < `HF_PIXELS; p++) begin
                centers[p] = int'(nextRand() & 32'hff);
            end
            if (m == 0) begin
                // edge bins so the window clamps at the low end
                centers[0] = 2;
                centers[1] = 252;
            end
            noHitPixel = (m == 2) ? 3 : -1;
            runPass(1'b0);
            // odd measurements write straight into the sweep stall
            if ((m % 2) == 0) begin
                checkRegs(m, 1'b1);
            end
            runPass(1'b1);
            checkRegs((m + 1) % 256, 1'b0);
        end

        if (writesIssued == acksSeen) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            failRun("write and ack counts differ at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
histPkg.sv
wbSampleSlave.sv
binSequencer.sv
histogramBank.sv
peakTracker.sv
resultFile.sv
peakFinderTop.sv
peakFinderTb.sv

/* run.sh */
#!/bin/sh
# build with verilator and run, exit status follows the simulation
verilator --binary --timing -f files.f --top-module peakFinderTb -o peakFinderSim \
    && ./obj_dir/peakFinderSim \
    || { echo "simulation failed"; exit 1; }
